/* Makefile */
TOP = msc_protocol_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

/* all.f */
rtl/msc_pkg.sv
rtl/cbw_parser.sv
rtl/csw_builder.sv
rtl/msc_sequencer.sv
rtl/msc_protocol.sv
verif/tb_clock_gen.sv
verif/msc_protocol_tb.sv

/* rtl/cbw_parser.sv */
`timescale 1ns/10ps
`default_nettype none

module cbw_parser (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    collect,        // Idle or receive phase
    input  wire msc_pkg::word_t    rx_data,
    input  wire                    rx_valid,
    output logic                   cbw_done,
    output logic                   cbw_ok,
    output msc_pkg::word_t         cbw_tag,
    output msc_pkg::word_t         cbw_length,
    output logic                   cbw_dir_in,
    output logic [3:0]             cbw_lun,
    output logic [4:0]             cbw_cb_length,
    output msc_pkg::cdb_t          cdb
);

    logic [2:0] word_cnt;   // Index of next CBW word
    logic [1:0] cdb_idx;    // CDB word slot
    logic       sig_bad;    // Word 0 was not "USBC"
    logic       accept;

    // rx_ready is high whenever collect is, so valid alone completes a beat
    assign accept  = collect && rx_valid;
    assign cdb_idx = 2'(word_cnt - 3'(msc_pkg::cbw_words - msc_pkg::cdb_words));

    // ==============================
    // Word counter and done pulse
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt <= '0;
            cbw_done <= 1'b0;
        end else begin
            cbw_done <= accept && (word_cnt == 3'(msc_pkg::cbw_words - 1));
            if (accept) begin
                word_cnt <= word_cnt + 3'd1;   // Wraps to 0 after word 7
            end
        end
    end

    // ==============================
    // Field capture
    // ==============================
    always_ff @(posedge clk) begin
        if (accept) begin
            case (word_cnt)
                3'd0: sig_bad    <= (rx_data != msc_pkg::cbw_signature);
                3'd1: cbw_tag    <= rx_data;
                3'd2: cbw_length <= rx_data;   // dCBWDataTransferLength
                3'd3: begin
                    cbw_dir_in    <= rx_data[7];       // bmCBWFlags bit 7
                    cbw_lun       <= rx_data[11:8];    // bCBWLUN
                    cbw_cb_length <= rx_data[20:16];   // bCBWCBLength
                end
                default: cdb[cdb_idx*msc_pkg::word_w +: msc_pkg::word_w] <= rx_data;
            endcase
        end
    end

    // Judged on the captured fields, sampled with cbw_done
    assign cbw_ok = !sig_bad
                 && (cbw_lun < msc_pkg::max_luns)
                 && (cbw_cb_length != 5'd0)
                 && (cbw_cb_length <= msc_pkg::max_cb_len);

    // Eight beats separate any two CBWs
    done_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) cbw_done |=> !cbw_done
    ) else $error("cbw_done high two cycles running");

endmodule

`default_nettype wire

/* rtl/csw_builder.sv */
`timescale 1ns/10ps
`default_nettype none

module csw_builder (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    status_take,
    input  wire                    error_take,
    input  wire                    csw_start,
    input  wire [7:0]              scsi_status,
    input  wire msc_pkg::word_t    scsi_residue,
    input  wire msc_pkg::word_t    cbw_tag,
    input  wire msc_pkg::word_t    cbw_length,
    input  wire                    tx_ready,
    output msc_pkg::word_t         csw_word,
    output logic                   csw_valid,
    output logic                   csw_last_accept
);

    msc_pkg::csw_status_t status;
    msc_pkg::word_t       residue;
    logic [1:0]           word_idx;   // CSW word on the bus
    logic                 accept;

    assign accept          = csw_valid && tx_ready;
    assign csw_last_accept = accept && (word_idx == 2'(msc_pkg::csw_words - 1));

    // Status and residue capture
    always_ff @(posedge clk) begin
        if (status_take) begin
            residue <= scsi_residue;
            if (scsi_status == 8'h00) begin
                status <= msc_pkg::pass;
            end else begin
                status <= msc_pkg::fail;   // Any nonzero SCSI status
            end
        end else if (error_take) begin
            residue <= cbw_length;             // Nothing moved
            status  <= msc_pkg::phase_error;
        end
    end

    // ==============================
    // Serializer
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_idx  <= '0;
            csw_valid <= 1'b0;
        end else if (csw_start) begin
            word_idx  <= '0;
            csw_valid <= 1'b1;
        end else if (accept) begin
            word_idx <= word_idx + 2'd1;   // Advance on acceptance only
            if (csw_last_accept) begin
                csw_valid <= 1'b0;
            end
        end
    end

    always_comb begin
        case (word_idx)
            2'd0:    csw_word = msc_pkg::csw_signature;
            2'd1:    csw_word = cbw_tag;   // dCSWTag echo
            2'd2:    csw_word = residue;
            default: csw_word = {{(msc_pkg::word_w - 8){1'b0}}, status};
        endcase
    end

    // Host back-pressure must not disturb the pending word
    word_hold: assert property (
        @(posedge clk) disable iff (!rst_n) (csw_valid && !tx_ready) |=> $stable(csw_word)
    ) else $error("csw_word changed while stalled");

endmodule

`default_nettype wire

/* rtl/msc_pkg.sv */
`default_nettype none

package msc_pkg;

    // ==============================
    // Widths and types
    // ==============================
    localparam int word_w = 32;                   // USB and sector buffer word
    localparam int cdb_w  = 128;                  // Packed 16-byte CDB

    typedef logic [word_w-1:0] word_t;
    typedef logic [cdb_w-1:0]  cdb_t;

    // ==============================
    // Wrapper constants
    // ==============================
    localparam word_t cbw_signature = 32'h4342_5355;   // "USBC", little endian
    localparam word_t csw_signature = 32'h5342_5355;   // "USBS"

    localparam int cbw_words = 8;                 // 31 bytes padded to 8 words
    localparam int cdb_words = 4;                 // Last four CBW words
    localparam int csw_words = 4;                 // 13 bytes padded to 4 words

    // Validity limits
    localparam int max_luns   = 4;
    localparam int max_cb_len = 16;

    // bCSWStatus codes
    typedef enum logic [7:0] {
        pass        = 8'h00,
        fail        = 8'h01,
        phase_error = 8'h02
    } csw_status_t;

endpackage

`default_nettype wire

/* rtl/msc_protocol.sv */
`timescale 1ns/10ps
`default_nettype none

module msc_protocol (
    input  wire                    clk,
    input  wire                    rst_n,
    // USB receive stream
    input  wire msc_pkg::word_t    rx_data,
    input  wire                    rx_valid,
    output logic                   rx_ready,
    // USB transmit stream
    output msc_pkg::word_t         tx_data,
    output logic                   tx_valid,
    input  wire                    tx_ready,
    // SCSI engine
    output msc_pkg::cdb_t          scsi_cdb,
    output logic [7:0]             scsi_cdb_length,
    output logic [2:0]             scsi_lun,
    output msc_pkg::word_t         scsi_xfer_length,
    output logic                   scsi_cmd_valid,
    input  wire                    scsi_cmd_ready,
    output logic                   scsi_data_in,
    output logic                   scsi_data_out,
    input  wire                    scsi_xfer_done,
    input  wire [7:0]              scsi_status,
    input  wire msc_pkg::word_t    scsi_residue,
    input  wire                    scsi_status_valid,
    output logic                   scsi_status_ready,
    // Sector buffer
    output msc_pkg::word_t         buf_wr_data,
    output logic                   buf_wr_valid,
    input  wire                    buf_wr_ready,
    input  wire msc_pkg::word_t    buf_rd_data,
    input  wire                    buf_rd_valid,
    output logic                   buf_rd_ready,
    output logic                   transfer_done
);

    // Parser outputs
    logic           collect;
    logic           cbw_done;
    logic           cbw_ok;
    msc_pkg::word_t cbw_tag;
    msc_pkg::word_t cbw_length;
    logic           cbw_dir_in;
    logic [3:0]     cbw_lun;
    logic [4:0]     cbw_cb_length;
    msc_pkg::cdb_t  cdb;

    // Sequencer and builder handshake
    logic           status_take;
    logic           error_take;
    logic           csw_start;
    msc_pkg::word_t csw_word;
    logic           csw_valid;
    logic           csw_last_accept;

    assign buf_wr_data = rx_data;   // Qualified by buf_wr_valid

    cbw_parser cbw_parser_inst (
        .clk, .rst_n, .collect, .rx_data, .rx_valid,
        .cbw_done, .cbw_ok, .cbw_tag, .cbw_length,
        .cbw_dir_in, .cbw_lun, .cbw_cb_length, .cdb
    );

    msc_sequencer msc_sequencer_inst (
        .clk, .rst_n, .cbw_done, .cbw_ok, .cbw_length, .cbw_dir_in,
        .cbw_lun, .cbw_cb_length, .cdb,
        .scsi_cmd_ready, .scsi_xfer_done, .scsi_status_valid,
        .rx_valid, .tx_ready, .buf_wr_ready, .buf_rd_data, .buf_rd_valid,
        .csw_word, .csw_valid, .csw_last_accept,
        .collect, .scsi_cdb, .scsi_cdb_length, .scsi_lun, .scsi_xfer_length,
        .scsi_cmd_valid, .scsi_data_in, .scsi_data_out, .scsi_status_ready,
        .rx_ready, .tx_data, .tx_valid, .buf_wr_valid, .buf_rd_ready,
        .status_take, .error_take, .csw_start, .transfer_done
    );

    csw_builder csw_builder_inst (
        .clk, .rst_n, .status_take, .error_take, .csw_start,
        .scsi_status, .scsi_residue, .cbw_tag, .cbw_length, .tx_ready,
        .csw_word, .csw_valid, .csw_last_accept
    );

endmodule

`default_nettype wire

/* rtl/msc_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module msc_sequencer (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    cbw_done,
    input  wire                    cbw_ok,
    input  wire msc_pkg::word_t    cbw_length,
    input  wire                    cbw_dir_in,
    input  wire [3:0]              cbw_lun,
    input  wire [4:0]              cbw_cb_length,
    input  wire msc_pkg::cdb_t     cdb,
    input  wire                    scsi_cmd_ready,
    input  wire                    scsi_xfer_done,
    input  wire                    scsi_status_valid,
    input  wire                    rx_valid,
    input  wire                    tx_ready,
    input  wire                    buf_wr_ready,
    input  wire msc_pkg::word_t    buf_rd_data,
    input  wire                    buf_rd_valid,
    input  wire msc_pkg::word_t    csw_word,
    input  wire                    csw_valid,
    input  wire                    csw_last_accept,
    output logic                   collect,
    output msc_pkg::cdb_t          scsi_cdb,
    output logic [7:0]             scsi_cdb_length,
    output logic [2:0]             scsi_lun,
    output msc_pkg::word_t         scsi_xfer_length,
    output logic                   scsi_cmd_valid,
    output logic                   scsi_data_in,
    output logic                   scsi_data_out,
    output logic                   scsi_status_ready,
    output logic                   rx_ready,
    output msc_pkg::word_t         tx_data,
    output logic                   tx_valid,
    output logic                   buf_wr_valid,
    output logic                   buf_rd_ready,
    output logic                   status_take,
    output logic                   error_take,
    output logic                   csw_start,
    output logic                   transfer_done
);

    typedef enum logic [2:0] {
        st_receive, st_command, st_data_in, st_data_out, st_wait_status, st_error, st_csw
    } state_t;

    state_t state;
    state_t state_next;
    logic   xfer_zero;   // No data phase

    assign xfer_zero = (scsi_xfer_length == '0);

    // ==============================
    // Phase FSM
    // ==============================
    always_comb begin
        state_next = state;
        case (state)
            st_receive:
                if (cbw_done) state_next = cbw_ok ? st_command : st_error;
            st_command:
                if (scsi_cmd_ready) begin
                    if (xfer_zero)       state_next = st_wait_status;
                    else if (cbw_dir_in) state_next = st_data_in;
                    else                 state_next = st_data_out;
                end
            st_data_in, st_data_out:
                if (scsi_xfer_done) state_next = st_wait_status;
            st_wait_status:
                if (scsi_status_valid) state_next = st_csw;
            st_error:
                state_next = st_csw;   // Phase error CSW
            st_csw:
                if (csw_last_accept) state_next = st_receive;
            default:
                state_next = st_receive;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= st_receive;
            csw_start     <= 1'b0;
            transfer_done <= 1'b0;
        end else begin
            state         <= state_next;
            csw_start     <= status_take || error_take;   // One cycle after the take
            transfer_done <= csw_last_accept;
        end
    end

    // Command fields, loaded on entry to the command phase
    always_ff @(posedge clk) begin
        if (cbw_done && cbw_ok && (state == st_receive)) begin
            scsi_cdb         <= cdb;
            scsi_cdb_length  <= {3'b000, cbw_cb_length};
            scsi_lun         <= cbw_lun[2:0];   // Below max_luns once judged
            scsi_xfer_length <= cbw_length;
        end
    end

    // ==============================
    // Handshakes and steering
    // ==============================
    assign collect           = (state == st_receive);
    assign scsi_cmd_valid    = (state == st_command);
    assign scsi_data_in      = (state == st_data_in);
    assign scsi_data_out     = (state == st_data_out);
    assign scsi_status_ready = (state == st_wait_status);
    assign status_take       = scsi_status_ready && scsi_status_valid;
    assign error_take        = (state == st_error);

    // Host to buffer during data-out
    assign rx_ready     = collect || (scsi_data_out && buf_wr_ready);
    assign buf_wr_valid = scsi_data_out && rx_valid;

    // Buffer or CSW to host
    assign tx_data      = scsi_data_in ? buf_rd_data : csw_word;
    assign tx_valid     = scsi_data_in ? buf_rd_valid : ((state == st_csw) && csw_valid);
    assign buf_rd_ready = scsi_data_in && tx_ready;

    data_dir_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(scsi_data_in && scsi_data_out)
    ) else $error("data-in and data-out both active");

    // Engine handshake is sticky
    cmd_valid_held: assert property (
        @(posedge clk) disable iff (!rst_n) (scsi_cmd_valid && !scsi_cmd_ready) |=> scsi_cmd_valid
    ) else $error("scsi_cmd_valid dropped before scsi_cmd_ready");

endmodule

`default_nettype wire

/* verif/msc_protocol_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module msc_protocol_tb;

    localparam int rec_words = 17;    // Words per vector record
    localparam int max_vec   = 256;

    logic           clk;
    logic           rst_n;

    // Host, engine and buffer side
    msc_pkg::word_t rx_data;
    logic           rx_valid;
    logic           tx_ready;
    logic           scsi_cmd_ready;
    logic           scsi_xfer_done;
    logic [7:0]     scsi_status;
    msc_pkg::word_t scsi_residue;
    logic           scsi_status_valid;
    logic           buf_wr_ready;
    msc_pkg::word_t buf_rd_data;
    logic           buf_rd_valid;

    // Handler side
    logic           rx_ready;
    msc_pkg::word_t tx_data;
    logic           tx_valid;
    msc_pkg::cdb_t  scsi_cdb;
    logic [7:0]     scsi_cdb_length;
    logic [2:0]     scsi_lun;
    msc_pkg::word_t scsi_xfer_length;
    logic           scsi_cmd_valid;
    logic           scsi_data_in;
    logic           scsi_data_out;
    logic           scsi_status_ready;
    msc_pkg::word_t buf_wr_data;
    logic           buf_wr_valid;
    logic           buf_rd_ready;
    logic           transfer_done;

    msc_pkg::word_t vec [0:max_vec-1];   // Record count followed by the records
    integer         seed;
    int             num_records;
    int             cycle_cnt   = 0;
    int             cycle_limit = 20;

    tb_clock_gen clock_gen_inst (.clk, .rst_n);

    msc_protocol msc_protocol_inst (.*);

    // ==============================
    // Failure reporting
    // ==============================
    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
        abort_run($sformatf("ERROR: %s = 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic expect_value(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
        assert (got === exp) else report_mismatch(name, got, exp);
    endtask

    // Runaway guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            abort_run("simulation timed out");
        end
    end

    // ==============================
    // One transfer with host, engine and buffer in lockstep
    // ==============================
    task automatic run_record(input int base);
        msc_pkg::word_t cbw [0:7];
        msc_pkg::word_t data [0:3];
        msc_pkg::word_t csw_exp [0:3];
        msc_pkg::word_t stall_word;
        logic [31:0]    rnd;
        logic           valid_cbw;
        logic           xfer_sent;
        logic           status_done;
        logic           in_seen;
        logic           out_seen;
        logic           stall_pend;
        logic           finished;
        int             n_data;
        int             sent;
        int             moved;
        int             csw_got;
        int             cmd_count;

        for (int i = 0; i < 8; i++) begin
            cbw[i] = vec[base + i];
        end
        for (int i = 0; i < 4; i++) begin
            data[i] = vec[base + 11 + i];
        end
        n_data     = int'(vec[base + 10]);
        csw_exp[0] = msc_pkg::csw_signature;
        csw_exp[1] = cbw[1];                 // Tag echo
        csw_exp[2] = vec[base + 16];
        csw_exp[3] = vec[base + 15];
        // Signature, LUN range, CB length 1..16
        valid_cbw  = (cbw[0] == msc_pkg::cbw_signature)
                  && (int'(cbw[3][11:8]) < msc_pkg::max_luns)
                  && (cbw[3][20:16] != 5'd0)
                  && (int'(cbw[3][20:16]) <= msc_pkg::max_cb_len);
        sent        = 0;
        moved       = 0;
        csw_got     = 0;
        cmd_count   = 0;
        xfer_sent   = 1'b0;
        status_done = 1'b0;
        in_seen     = 1'b0;
        out_seen    = 1'b0;
        stall_pend  = 1'b0;
        stall_word  = '0;
        finished    = 1'b0;

        scsi_status  <= vec[base + 8][7:0];
        scsi_residue <= vec[base + 9];
        rx_data      <= cbw[0];
        rx_valid     <= 1'b1;

        while (!finished) begin
            @(posedge clk);
            if (stall_pend) begin                      // Held CSW word
                expect_value("tx_valid", tx_valid, 1'b1);
                expect_value("tx_data", tx_data, stall_word);
            end
            if (rx_valid && rx_ready) begin
                if (sent < 8) begin
                    sent++;
                end else begin
                    assert (moved < n_data) else abort_run("host word taken past the record");
                    expect_value("buf_wr_valid", buf_wr_valid, 1'b1);
                    expect_value("buf_wr_data", buf_wr_data, data[moved]);
                    moved++;
                end
            end
            if (scsi_data_out) begin
                out_seen = 1'b1;
                expect_value("rx_ready", rx_ready, buf_wr_ready);
            end
            if (scsi_data_in) begin
                in_seen = 1'b1;
                expect_value("buf_rd_ready", buf_rd_ready, tx_ready);
                expect_value("tx_valid", tx_valid, buf_rd_valid);
                if (tx_valid && tx_ready) begin
                    assert (moved < n_data) else abort_run("buffer word sent past the record");
                    expect_value("tx_data", tx_data, data[moved]);
                    moved++;
                end
            end else if (tx_valid && tx_ready) begin
                assert (csw_got < 4) else abort_run("more than four CSW words sent");
                expect_value("tx_data", tx_data, csw_exp[csw_got]);
                csw_got++;
            end
            if (scsi_cmd_valid) begin
                assert (valid_cbw) else abort_run("SCSI command issued for an invalid CBW");
                if (scsi_cmd_ready) begin
                    cmd_count++;
                    expect_value("scsi_cdb", scsi_cdb, {cbw[7], cbw[6], cbw[5], cbw[4]});
                    expect_value("scsi_cdb_length", scsi_cdb_length, cbw[3][20:16]);
                    expect_value("scsi_lun", scsi_lun, cbw[3][10:8]);
                    expect_value("scsi_xfer_length", scsi_xfer_length, cbw[2]);
                end
            end
            if (scsi_status_valid && scsi_status_ready) begin
                status_done = 1'b1;
            end
            if (transfer_done) begin
                assert ((sent == 8) && (csw_got == 4))
                    else abort_run("transfer_done before the CBW and CSW were complete");
                finished = 1'b1;
            end
            stall_pend = tx_valid && !tx_ready && !scsi_data_in;
            stall_word = tx_data;

            // Next cycle's inputs
            rnd = $random(seed);
            tx_ready     <= rnd[0];
            buf_wr_ready <= rnd[1];
            if (sent < 8) begin
                rx_data  <= cbw[sent];
                rx_valid <= 1'b1;
            end else if (scsi_data_out && (moved < n_data)) begin
                rx_data  <= data[moved];               // Held until taken
                rx_valid <= 1'b1;
            end else begin
                rx_valid <= 1'b0;
            end
            buf_rd_valid   <= scsi_data_in && (moved < n_data) && rnd[2];
            buf_rd_data    <= (moved < n_data) ? data[moved] : '0;
            scsi_cmd_ready <= scsi_cmd_valid && !scsi_cmd_ready && rnd[3];
            scsi_xfer_done <= (scsi_data_in || scsi_data_out) && (moved == n_data) && !xfer_sent;
            if ((scsi_data_in || scsi_data_out) && (moved == n_data)) begin
                xfer_sent = 1'b1;                      // Single strobe
            end
            scsi_status_valid <= scsi_status_ready && !status_done;
        end

        assert (cmd_count == (valid_cbw ? 1 : 0)) else abort_run("wrong number of SCSI commands");
        assert (moved == n_data) else abort_run("not every data word was moved");
        assert (in_seen == (valid_cbw && cbw[3][7] && (cbw[2] != '0)))
            else abort_run("data-in phase missing or unexpected");
        assert (out_seen == (valid_cbw && !cbw[3][7] && (cbw[2] != '0)))
            else abort_run("data-out phase missing or unexpected");
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        rx_data           = '0;
        rx_valid          = 1'b0;
        tx_ready          = 1'b0;
        scsi_cmd_ready    = 1'b0;
        scsi_xfer_done    = 1'b0;
        scsi_status       = '0;
        scsi_residue      = '0;
        scsi_status_valid = 1'b0;
        buf_wr_ready      = 1'b0;
        buf_rd_data       = '0;
        buf_rd_valid      = 1'b0;
        seed              = 32'hb750_ab29;

        $readmemh("verif/msc_vectors.hex", vec);
        num_records = int'(vec[0]);
        cycle_limit = num_records * 300 + 20;

        wait (rst_n === 1'b1);
        @(posedge clk);
        expect_value("rx_ready", rx_ready, 1'b1);     // Idle outputs out of reset
        expect_value("tx_valid", tx_valid, 1'b0);
        expect_value("scsi_cmd_valid", scsi_cmd_valid, 1'b0);
        expect_value("scsi_data_in", scsi_data_in, 1'b0);
        expect_value("scsi_data_out", scsi_data_out, 1'b0);
        expect_value("scsi_status_ready", scsi_status_ready, 1'b0);
        expect_value("buf_wr_valid", buf_wr_valid, 1'b0);
        expect_value("buf_rd_ready", buf_rd_ready, 1'b0);
        expect_value("transfer_done", transfer_done, 1'b0);

        for (int r = 0; r < num_records; r++) begin
            run_record(1 + r * rec_words);
        end
        @(posedge clk);
        expect_value("transfer_done", transfer_done, 1'b0);   // One-cycle pulse

        if (num_records > 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            abort_run("no test records were read");
        end
    end

endmodule

`default_nettype wire

/* verif/msc_vectors.hex */
// Per record: 8 CBW words | engine status, residue | data count, 4 data words
// | expected CSW status, residue. The first word is the record count
00000008
// Test unit ready, zero length, LUN 0
43425355 00000001 00000000 00060000 11223344 55667788 99aabbcc ddeeff00
00000000 00000000
00000000 00000000 00000000 00000000 00000000
00000000 00000000
// Read, data-in 4 words, engine reports check condition
43425355 00000002 00000010 280a0180 00001000 00000800 01000000 00000000
00000002 00000004
00000004 a5a50001 a5a50002 a5a50003 a5a50004
00000001 00000004
// Write, data-out 3 words
43425355 00000003 0000000c 2a0a0200 00002000 00000300 01000000 00000000
00000000 00000000
00000003 5a5a1111 5a5a2222 5a5a3333 00000000
00000000 00000000
// Bad signature
43425354 00000004 00000200 280a0080 00000000 00000000 00000000 00000000
00000000 00000000
00000000 00000000 00000000 00000000 00000000
00000002 00000200
// LUN 4, out of range
43425355 00000005 00000100 280a0480 00000000 00000000 00000000 00000000
00000000 00000000
00000000 00000000 00000000 00000000 00000000
00000002 00000100
// CB length 0
43425355 00000006 00000040 00000000 00000000 00000000 00000000 00000000
00000000 00000000
00000000 00000000 00000000 00000000 00000000
00000002 00000040
// CB length 17
43425355 00000007 00000008 00110100 00000000 00000000 00000000 00000000
00000000 00000000
00000000 00000000 00000000 00000000 00000000
00000002 00000008
// Zero length on LUN 3 after the errors, engine fails it
43425355 00000008 00000000 000c0300 00000003 00000000 00000000 00000000
00000001 00000000
00000000 00000000 00000000 00000000 00000000
00000001 00000000

/* verif/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int half_period  = 20;   // 40 ns clock
    localparam int reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Reset held low over the first rising edges
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;   // Released on an edge, seen at the next one
    end

endmodule

`default_nettype wire
